/* logic/ym2610.sv */
`timescale 1ns/100ps

module ym2610(
	input logic phiS,
	input logic rst,
	input logic [ymRegPkg::dataWidth-1:0] sddIn,
	input logic [1:0] sda,
	input logic nCs,
	input logic nWr,
	input logic nRd,
	output logic [ymRegPkg::dataWidth-1:0] sddOut,
	output logic nIrq,
	output logic [ymSoundPkg::anaWidth-1:0] ana
);

	ymRegBus regBus();
	timerCtrlIf timerCtrl();
	ssgCtrlIf ssgCtrl();

	ymBusPort busPort0(
		.phiS(phiS),
		.rst(rst),
		.sddIn(sddIn),
		.sda(sda),
		.nCs(nCs),
		.nWr(nWr),
		.nRd(nRd),
		.sddOut(sddOut),
		.regBus(regBus.source),
		.timerCtrl(timerCtrl.status)
	);

	ymRegFile regFile0(
		.phiS(phiS),
		.rst(rst),
		.regBus(regBus.sink),
		.timerCtrl(timerCtrl.ctrl),
		.ssgCtrl(ssgCtrl.ctrl)
	);

	ymTimer timer0(
		.phiS(phiS),
		.rst(rst),
		.timerCtrl(timerCtrl.timer),
		.nIrq(nIrq)
	);

	ymSsg ssg0(
		.phiS(phiS),
		.rst(rst),
		.ssgCtrl(ssgCtrl.ssg),
		.ana(ana)
	);

endmodule

/* logic/ymBusPort.sv */
`timescale 1ns/100ps

module ymBusPort(
	input logic phiS,
	input logic rst,
	input logic [ymRegPkg::dataWidth-1:0] sddIn,
	input logic [1:0] sda,
	input logic nCs,
	input logic nWr,
	input logic nRd,
	output logic [ymRegPkg::dataWidth-1:0] sddOut,
	ymRegBus.source regBus,
	timerCtrlIf.status timerCtrl
);
	import ymRegPkg::*;

	logic csR;
	logic wrR;
	logic rdR;
	logic [1:0] sdaR;
	logic [dataWidth-1:0] sddR;
	logic wrActive;
	logic wrActiveD;
	logic wrStart;
	logic [dataWidth-1:0] addrOne;
	logic [dataWidth-1:0] addrTwo;
	logic [dataWidth-1:0] status;

	always_ff @(posedge phiS)
	begin
		if (rst)
		begin
			csR <= 1'b1;
			wrR <= 1'b1;
			rdR <= 1'b1;
			wrActiveD <= 1'b0;
		end
		else
		begin
			csR <= nCs;
			wrR <= nWr;
			rdR <= nRd;
			wrActiveD <= wrActive;
		end
	end

	always_ff @(posedge phiS)
	begin
		sdaR <= sda;
		sddR <= sddIn;
	end

	assign wrActive = !csR && !wrR && rdR;
	assign wrStart = wrActive && !wrActiveD;	// First cycle of a write

	always_ff @(posedge phiS)
	begin
		if (rst)
		begin
			addrOne <= '0;
			addrTwo <= '0;
			regBus.wrStrobe <= 1'b0;
		end
		else
		begin
			regBus.wrStrobe <= wrStart && sdaR[0];
			if (wrStart && !sdaR[0])
			begin
				if (sdaR[1] == zoneTwo)
					addrTwo <= sddR;
				else
					addrOne <= sddR;
			end
		end
	end

	// Zone, address and data only matter alongside wrStrobe
	always_ff @(posedge phiS)
	begin
		regBus.zone <= sdaR[1];
		regBus.addr <= (sdaR[1] == zoneTwo) ? addrTwo : addrOne;
		regBus.data <= sddR;
	end

	always_comb
	begin
		status = '0;
		status[statusBitA] = timerCtrl.flagA;
		status[statusBitB] = timerCtrl.flagB;
	end

	always_ff @(posedge phiS)
	begin
		if (rst)
			sddOut <= '0;
		else
			sddOut <= (!csR && !rdR) ? status : '0;
	end

	wrStrobeSingle: assert property (@(posedge phiS) disable iff (rst)
		regBus.wrStrobe |=> !regBus.wrStrobe);

endmodule

/* logic/ymCtrlIf.sv */
`timescale 1ns/100ps

interface ymRegBus;
	import ymRegPkg::*;

	logic wrStrobe;
	logic zone;
	logic [dataWidth-1:0] addr;
	logic [dataWidth-1:0] data;

	modport source(output wrStrobe, zone, addr, data);
	modport sink(input wrStrobe, zone, addr, data);
endinterface

interface timerCtrlIf;
	import ymSoundPkg::*;

	logic [taWidth-1:0] taLoad;
	logic [tbWidth-1:0] tbLoad;
	logic runA;
	logic runB;
	logic irqEnA;
	logic irqEnB;
	logic clrA;
	logic clrB;
	logic flagA;
	logic flagB;

	modport ctrl(output taLoad, tbLoad, runA, runB, irqEnA, irqEnB, clrA, clrB);
	modport timer(input taLoad, tbLoad, runA, runB, irqEnA, irqEnB, clrA, clrB,
		output flagA, flagB);
	modport status(input flagA, flagB);
endinterface

interface ssgCtrlIf;
	import ymSoundPkg::*;

	logic [toneWidth-1:0] freqA;
	logic [toneWidth-1:0] freqB;
	logic [toneWidth-1:0] freqC;
	logic [noiseWidth-1:0] noisePeriod;
	logic [5:0] mixer;	// Active low
	logic [levelWidth:0] volA;
	logic [levelWidth:0] volB;
	logic [levelWidth:0] volC;
	logic [envFreqWidth-1:0] envFreq;
	logic [3:0] envShape;
	logic envRestart;

	modport ctrl(output freqA, freqB, freqC, noisePeriod, mixer, volA, volB, volC,
		envFreq, envShape, envRestart);
	modport ssg(input freqA, freqB, freqC, noisePeriod, mixer, volA, volB, volC,
		envFreq, envShape, envRestart);
endinterface

/* logic/ymRegFile.sv */
`timescale 1ns/100ps

module ymRegFile(
	input logic phiS,
	input logic rst,
	ymRegBus.sink regBus,
	timerCtrlIf.ctrl timerCtrl,
	ssgCtrlIf.ctrl ssgCtrl
);
	import ymRegPkg::*;

	logic wrZoneOne;
	logic cfgWrite;

	assign wrZoneOne = regBus.wrStrobe && (regBus.zone == zoneOne);	// Zone 2 dropped here
	assign cfgWrite = wrZoneOne && (regBus.addr == regTimerCfg);

	always_ff @(posedge phiS)
	begin
		if (rst)
		begin
			ssgCtrl.freqA <= '0;
			ssgCtrl.freqB <= '0;
			ssgCtrl.freqC <= '0;
			ssgCtrl.noisePeriod <= '0;
			ssgCtrl.mixer <= mixerReset;
			ssgCtrl.volA <= '0;
			ssgCtrl.volB <= '0;
			ssgCtrl.volC <= '0;
			ssgCtrl.envFreq <= '0;
			ssgCtrl.envShape <= '0;
			timerCtrl.taLoad <= '0;
			timerCtrl.tbLoad <= '0;
			timerCtrl.runA <= 1'b0;
			timerCtrl.runB <= 1'b0;
			timerCtrl.irqEnA <= 1'b0;
			timerCtrl.irqEnB <= 1'b0;
		end
		else if (wrZoneOne)
		begin
			case (regBus.addr)
				regFreqALo: ssgCtrl.freqA[7:0] <= regBus.data;
				regFreqAHi: ssgCtrl.freqA[11:8] <= regBus.data[3:0];
				regFreqBLo: ssgCtrl.freqB[7:0] <= regBus.data;
				regFreqBHi: ssgCtrl.freqB[11:8] <= regBus.data[3:0];
				regFreqCLo: ssgCtrl.freqC[7:0] <= regBus.data;
				regFreqCHi: ssgCtrl.freqC[11:8] <= regBus.data[3:0];
				regNoise: ssgCtrl.noisePeriod <= regBus.data[4:0];
				regMixer: ssgCtrl.mixer <= regBus.data[5:0];
				regVolA: ssgCtrl.volA <= regBus.data[4:0];
				regVolB: ssgCtrl.volB <= regBus.data[4:0];
				regVolC: ssgCtrl.volC <= regBus.data[4:0];
				regEnvLo: ssgCtrl.envFreq[7:0] <= regBus.data;
				regEnvHi: ssgCtrl.envFreq[15:8] <= regBus.data;
				regEnvShape: ssgCtrl.envShape <= regBus.data[3:0];
				regTaLo: timerCtrl.taLoad[7:0] <= regBus.data;
				regTaHi: timerCtrl.taLoad[9:8] <= regBus.data[1:0];
				regTb: timerCtrl.tbLoad <= regBus.data;
				regTimerCfg:
				begin
					timerCtrl.runA <= regBus.data[cfgRunA];
					timerCtrl.runB <= regBus.data[cfgRunB];
					timerCtrl.irqEnA <= regBus.data[cfgIrqA];
					timerCtrl.irqEnB <= regBus.data[cfgIrqB];
				end
				default: ;	// Unused addresses
			endcase
		end
	end

	// One-cycle strobes, aligned with the register update
	always_ff @(posedge phiS)
	begin
		if (rst)
		begin
			timerCtrl.clrA <= 1'b0;
			timerCtrl.clrB <= 1'b0;
			ssgCtrl.envRestart <= 1'b0;
		end
		else
		begin
			timerCtrl.clrA <= cfgWrite && regBus.data[cfgClrA];
			timerCtrl.clrB <= cfgWrite && regBus.data[cfgClrB];
			ssgCtrl.envRestart <= wrZoneOne && (regBus.addr == regEnvShape);
		end
	end

	clrASingle: assert property (@(posedge phiS) disable iff (rst)
		timerCtrl.clrA |=> !timerCtrl.clrA);

endmodule

/* logic/ymRegPkg.sv */
package ymRegPkg;

	localparam int dataWidth = 8;

	// Zone select on sda[1]
	localparam logic zoneOne = 1'b0;
	localparam logic zoneTwo = 1'b1;

	localparam int statusBitA = 0;
	localparam int statusBitB = 1;

	localparam logic [7:0] regFreqALo = 8'h00;
	localparam logic [7:0] regFreqAHi = 8'h01;
	localparam logic [7:0] regFreqBLo = 8'h02;
	localparam logic [7:0] regFreqBHi = 8'h03;
	localparam logic [7:0] regFreqCLo = 8'h04;
	localparam logic [7:0] regFreqCHi = 8'h05;
	localparam logic [7:0] regNoise = 8'h06;
	localparam logic [7:0] regMixer = 8'h07;
	localparam logic [7:0] regVolA = 8'h08;
	localparam logic [7:0] regVolB = 8'h09;
	localparam logic [7:0] regVolC = 8'h0A;
	localparam logic [7:0] regEnvLo = 8'h0B;
	localparam logic [7:0] regEnvHi = 8'h0C;
	localparam logic [7:0] regEnvShape = 8'h0D;
	localparam logic [7:0] regTaLo = 8'h24;
	localparam logic [7:0] regTaHi = 8'h25;
	localparam logic [7:0] regTb = 8'h26;
	localparam logic [7:0] regTimerCfg = 8'h27;

	localparam int cfgRunA = 0;
	localparam int cfgRunB = 1;
	localparam int cfgIrqA = 2;
	localparam int cfgIrqB = 3;
	localparam int cfgClrA = 4;
	localparam int cfgClrB = 5;

	localparam logic [5:0] mixerReset = 6'h3F;	// Tone and noise off everywhere

endpackage

/* logic/ymSoundPkg.sv */
package ymSoundPkg;

	// Clocks per step
	localparam int taPrescale = 8;
	localparam int tbPrescale = 128;
	localparam int ssgPrescale = 8;
	localparam int envDivide = 16;	// Extra envelope division over the SSG tick

	localparam int timerPreWidth = $clog2(tbPrescale);
	localparam int ssgPreWidth = $clog2(ssgPrescale);
	localparam int envPreWidth = $clog2(envDivide);

	localparam int taWidth = 10;
	localparam int tbWidth = 8;

	localparam int toneWidth = 12;
	localparam int noiseWidth = 5;
	localparam int lfsrWidth = 17;
	localparam int envFreqWidth = 16;
	localparam int levelWidth = 4;
	localparam int anaWidth = 6;
	localparam int anaMax = 45;	// Three channels at full scale

	// Envelope shape bits
	localparam int envHold = 0;
	localparam int envAlt = 1;
	localparam int envAttack = 2;
	localparam int envCont = 3;

endpackage

/* logic/ymSsg.sv */
`timescale 1ns/100ps

module ymSsg(
	input logic phiS,
	input logic rst,
	ssgCtrlIf.ssg ssgCtrl,
	output logic [ymSoundPkg::anaWidth-1:0] ana
);
	import ymSoundPkg::*;

	logic [ssgPreWidth-1:0] pre;
	logic tick;
	logic [toneWidth-1:0] freq [3];
	logic [levelWidth:0] vol [3];
	logic [toneWidth-1:0] toneCnt [3];
	logic [2:0] tone;
	logic [noiseWidth-1:0] noiseBase;
	logic [noiseWidth:0] noiseCnt;
	logic [lfsrWidth-1:0] lfsr;
	logic [envPreWidth-1:0] envPre;
	logic envSub;
	logic [envFreqWidth-1:0] envCnt;
	logic envTick;
	logic [levelWidth-1:0] envStep;
	logic [levelWidth-1:0] envLevel;
	logic envUp;
	logic envHeld;
	logic [levelWidth-1:0] level [3];
	logic [anaWidth-1:0] sum;

	assign freq = '{ssgCtrl.freqA, ssgCtrl.freqB, ssgCtrl.freqC};
	assign vol = '{ssgCtrl.volA, ssgCtrl.volB, ssgCtrl.volC};

	assign tick = (pre == ssgPreWidth'(ssgPrescale - 1));
	assign noiseBase = (ssgCtrl.noisePeriod == '0) ? noiseWidth'(1) : ssgCtrl.noisePeriod;

	always_ff @(posedge phiS)
	begin
		if (rst)
		begin
			pre <= '0;
			tone <= '0;
			noiseCnt <= '0;
			lfsr <= lfsrWidth'(1);
			for (int i = 0; i < 3; i++)
				toneCnt[i] <= '0;
		end
		else
		begin
			pre <= tick ? '0 : pre + 1'b1;
			if (tick)
			begin
				for (int i = 0; i < 3; i++)
				begin
					if (toneCnt[i] + 1'b1 >= freq[i])	// Period 0 acts as 1
					begin
						toneCnt[i] <= '0;
						tone[i] <= ~tone[i];
					end
					else
						toneCnt[i] <= toneCnt[i] + 1'b1;
				end

				if (noiseCnt + 1'b1 >= {noiseBase, 1'b0})
				begin
					noiseCnt <= '0;
					lfsr <= {lfsr[0] ^ lfsr[3], lfsr[lfsrWidth-1:1]};
				end
				else
					noiseCnt <= noiseCnt + 1'b1;
			end
		end
	end

	assign envSub = tick && (envPre == envPreWidth'(envDivide - 1));
	assign envTick = envSub && (envCnt + 1'b1 >= ssgCtrl.envFreq);

	always_ff @(posedge phiS)
	begin
		if (rst)
		begin
			envPre <= '0;
			envCnt <= '0;
			envStep <= '0;
			envLevel <= '0;
			envUp <= 1'b0;
			envHeld <= 1'b1;	// Silent until a shape is written
		end
		else if (ssgCtrl.envRestart)
		begin
			envPre <= '0;
			envCnt <= '0;
			envStep <= '0;
			envUp <= ssgCtrl.envShape[envAttack];
			envLevel <= ssgCtrl.envShape[envAttack] ? '0 : '1;
			envHeld <= 1'b0;
		end
		else
		begin
			if (tick)
				envPre <= envSub ? '0 : envPre + 1'b1;
			if (envSub)
				envCnt <= envTick ? '0 : envCnt + 1'b1;

			if (envTick && !envHeld)
			begin
				envStep <= envStep + 1'b1;
				if (envStep != '1)
					envLevel <= envUp ? envLevel + 1'b1 : envLevel - 1'b1;
				else if (!ssgCtrl.envShape[envCont])
				begin
					envLevel <= '0;
					envHeld <= 1'b1;
				end
				else if (ssgCtrl.envShape[envHold])
				begin
					envHeld <= 1'b1;
					if (ssgCtrl.envShape[envAlt])
						envLevel <= ~envLevel;
				end
				else if (ssgCtrl.envShape[envAlt])
					envUp <= ~envUp;	// Triangle
				else
					envLevel <= envUp ? '0 : '1;	// Sawtooth
			end
		end
	end

	// Mixer bits 0-2 gate tone, 3-5 gate noise
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < 3; i++)
		begin
			if ((tone[i] | ssgCtrl.mixer[i]) & (lfsr[0] | ssgCtrl.mixer[i + 3]))
				level[i] = vol[i][levelWidth] ? envLevel : vol[i][levelWidth-1:0];
			else
				level[i] = '0;
			sum = sum + anaWidth'(level[i]);
		end
	end

	always_ff @(posedge phiS)
	begin
		if (rst)
			ana <= '0;
		else
			ana <= sum;
	end

	anaInRange: assert property (@(posedge phiS) disable iff (rst)
		ana <= anaWidth'(anaMax));

endmodule

/* logic/ymTimer.sv */
`timescale 1ns/100ps

module ymTimer(
	input logic phiS,
	input logic rst,
	timerCtrlIf.timer timerCtrl,
	output logic nIrq
);
	import ymSoundPkg::*;

	logic [1:0] run;
	logic [1:0] clr;
	logic [1:0] irqEn;
	logic [1:0] flag;
	logic [taWidth-1:0] load [2];

	assign run = {timerCtrl.runB, timerCtrl.runA};
	assign clr = {timerCtrl.clrB, timerCtrl.clrA};
	assign irqEn = {timerCtrl.irqEnB, timerCtrl.irqEnA};
	assign load[0] = timerCtrl.taLoad;
	assign load[1] = taWidth'(timerCtrl.tbLoad);

	// Index 0 is timer A, index 1 timer B
	for (genvar i = 0; i < 2; i++)
	begin : gTimer
		logic [timerPreWidth-1:0] pre;
		logic [taWidth-1:0] cnt;
		logic step;
		logic wrap;
		logic flagReg;

		assign step = run[i] && (pre == ((i == 0) ? timerPreWidth'(taPrescale - 1)
			: timerPreWidth'(tbPrescale - 1)));
		assign wrap = step && (cnt == ((i == 0) ? taWidth'((1 << taWidth) - 1)
			: taWidth'((1 << tbWidth) - 1)));

		always_ff @(posedge phiS)
		begin
			if (rst)
			begin
				pre <= '0;
				cnt <= '0;
				flagReg <= 1'b0;
			end
			else
			begin
				if (!run[i])
				begin
					pre <= '0;
					cnt <= load[i];	// Stopped timer sits at its load value
				end
				else if (step)
				begin
					pre <= '0;
					cnt <= wrap ? load[i] : cnt + 1'b1;
				end
				else
					pre <= pre + 1'b1;

				if (wrap)
					flagReg <= 1'b1;	// Set beats clear
				else if (clr[i])
					flagReg <= 1'b0;
			end
		end

		assign flag[i] = flagReg;
	end

	assign timerCtrl.flagA = flag[0];
	assign timerCtrl.flagB = flag[1];

	always_ff @(posedge phiS)
	begin
		if (rst)
			nIrq <= 1'b1;
		else
			nIrq <= ~|(flag & irqEn);
	end

	irqMasked: assert property (@(posedge phiS) disable iff (rst)
		(irqEn == 2'b00) |=> nIrq);

endmodule

/* sim.f */
+incdir+tests
logic/ymRegPkg.sv
logic/ymSoundPkg.sv
logic/ymCtrlIf.sv
logic/ymBusPort.sv
logic/ymRegFile.sv
logic/ymTimer.sv
logic/ymSsg.sv
logic/ym2610.sv
tests/ym2610Tb.sv

/* tests/ymTbTasks.svh */
// One clock, then settle 2 ns past the edge
task automatic nextCycle;
	@(posedge phiS);
	#2;
endtask

task automatic stopOnError(input string msg);
	errors++;
	$display("%s", msg);
	$display("Simulation finished: FAIL");
	$fatal(1, "Stopped at first error");
endtask

// Idle cycle first so every phase starts with a fresh falling edge
task automatic busPhase(input logic zone, input logic isData, input logic [7:0] value);
	nextCycle();
	sda = {zone, isData};
	sddIn = value;
	nCs = 1'b0;
	nWr = 1'b0;
	repeat (3) nextCycle();
	nCs = 1'b1;
	nWr = 1'b1;
endtask

task automatic busWrite(input logic zone, input logic [7:0] addr, input logic [7:0] data);
	busPhase(zone, 1'b0, addr);
	busPhase(zone, 1'b1, data);	// Register holds the value on return
endtask

task automatic busRead(output logic [dataWidth-1:0] value);
	nextCycle();
	nCs = 1'b0;
	nRd = 1'b0;
	repeat (3) nextCycle();
	value = sddOut;
	nCs = 1'b1;
	nRd = 1'b1;
endtask

task automatic checkAna(input string testName, input logic [anaWidth-1:0] expected,
	input logic [anaWidth-1:0] actual);
	if (actual !== expected)
		stopOnError($sformatf("Mismatch in %s: expected %0d, actual %0d",
			testName, expected, actual));
endtask

task automatic checkStatus(input string testName, input logic [dataWidth-1:0] expected,
	input logic [dataWidth-1:0] actual);
	if (actual !== expected)
		stopOnError($sformatf("Mismatch in %s: expected %h, actual %h",
			testName, expected, actual));
endtask

task automatic checkIrq(input string testName, input logic expected, input logic actual);
	if (actual !== expected)
		stopOnError($sformatf("Mismatch in %s: expected %b, actual %b",
			testName, expected, actual));
endtask

task automatic testResetAndVolumes;
	logic [dataWidth-1:0] st;
	integer r;
	logic [3:0] vols [3];
	logic [anaWidth-1:0] total;
	checkAna("reset", 6'd0, ana);
	checkIrq("reset", 1'b1, nIrq);
	busRead(st);
	checkStatus("reset", 8'h00, st);
	total = '0;
	for (int i = 0; i < 3; i++)
	begin
		r = $random(seed);
		vols[i] = r[3:0];
		total = total + vols[i];
	end
	busWrite(zoneOne, regMixer, 8'h3F);
	busWrite(zoneOne, regVolA, {4'h0, vols[0]});
	busWrite(zoneOne, regVolB, {4'h0, vols[1]});
	busWrite(zoneOne, regVolC, {4'h0, vols[2]});
	nextCycle();
	checkAna("fixed volumes", total, ana);
endtask

task automatic testTone;
	logic [anaWidth-1:0] first;
	logic [anaWidth-1:0] expected;
	logic highPhase;
	int waited;
	busWrite(zoneOne, regVolB, 8'h00);
	busWrite(zoneOne, regVolC, 8'h00);
	busWrite(zoneOne, regFreqALo, 8'h05);
	busWrite(zoneOne, regFreqAHi, 8'h00);
	busWrite(zoneOne, regVolA, 8'h0F);
	busWrite(zoneOne, regMixer, 8'h3E);	// Tone A only
	nextCycle();
	first = ana;
	waited = 0;
	while (ana === first && waited < 2 * tonePeriod + 8)
	begin
		nextCycle();
		waited++;
	end
	if (ana === first)
		stopOnError("Tone on channel A never toggled");
	highPhase = (ana === 6'd15);	// Tone phase at the first toggle
	checkAna("tone", highPhase ? 6'd15 : 6'd0, ana);
	for (int k = 1; k <= toneChecks; k++)
	begin
		nextCycle();
		expected = ((((k / tonePeriod) % 2) == 1) != highPhase) ? 6'd15 : 6'd0;
		checkAna("tone", expected, ana);
	end
endtask

task automatic testEnvelopeSetup;
	busWrite(zoneOne, regMixer, 8'h3F);
	busWrite(zoneOne, regVolA, 8'h10);	// Envelope on A
	busWrite(zoneOne, regVolB, 8'h00);
	busWrite(zoneOne, regVolC, 8'h00);
	busWrite(zoneOne, regEnvLo, 8'h01);
	busWrite(zoneOne, regEnvHi, 8'h00);
endtask

task automatic testEnvelope(input string testName, input logic [3:0] shape,
	input logic [anaWidth-1:0] settle, input logic rising);
	logic [anaWidth-1:0] prev;
	busWrite(zoneOne, regEnvShape, {4'h0, shape});
	prev = ana;
	for (int k = 0; k < envCycles; k++)
	begin
		nextCycle();
		if (rising ? (ana < prev) : (ana > prev))
			checkAna(testName, prev, ana);
		prev = ana;
	end
	checkAna(testName, settle, ana);
endtask

task automatic testTimerA;
	logic [dataWidth-1:0] st;
	int cycles;
	busWrite(zoneOne, regTaLo, 8'hFC);
	busWrite(zoneOne, regTaHi, 8'h03);	// Load 1020
	busWrite(zoneOne, regTimerCfg, 8'h05);
	cycles = 0;
	while (nIrq === 1'b1 && cycles < timerAPeriod + 16)
	begin
		nextCycle();
		cycles++;
	end
	checkIrq("timer A", 1'b0, nIrq);
	if (cycles < 24)
		stopOnError("Timer A interrupt came too early");
	busRead(st);
	checkStatus("timer A", 8'h01, st);
	busWrite(zoneOne, regTimerCfg, 8'h14);	// Clear A, stop
	repeat (2) nextCycle();
	checkIrq("timer A clear", 1'b1, nIrq);
	busRead(st);
	checkStatus("timer A clear", 8'h00, st);
endtask

task automatic testTimerB;
	logic [dataWidth-1:0] st;
	busWrite(zoneOne, regTb, 8'hFE);
	busWrite(zoneOne, regTimerCfg, 8'h02);
	for (int k = 0; k < timerBWait; k++)
	begin
		nextCycle();
		checkIrq("timer B", 1'b1, nIrq);
	end
	busRead(st);
	checkStatus("timer B", 8'h02, st);
	busWrite(zoneOne, regTimerCfg, 8'h20);
	nextCycle();
	busRead(st);
	checkStatus("timer B clear", 8'h00, st);
endtask

task automatic testZoneTwo;
	logic [dataWidth-1:0] st;
	busWrite(zoneOne, regVolB, 8'h07);
	nextCycle();
	checkAna("zone 2", 6'd7, ana);
	busWrite(zoneTwo, regVolB, 8'hFF);
	busWrite(zoneTwo, regMixer, 8'h00);
	busWrite(zoneTwo, regTimerCfg, 8'h0F);
	busWrite(zoneTwo, regVolC, 8'h0F);
	busWrite(zoneOne, 8'h0E, 8'hFF);
	busWrite(zoneOne, 8'h1F, 8'hFF);
	busWrite(zoneOne, 8'h28, 8'hFF);
	busWrite(zoneOne, 8'hFF, 8'hFF);
	repeat (2) nextCycle();
	checkAna("zone 2", 6'd7, ana);
	checkIrq("zone 2", 1'b1, nIrq);
	busRead(st);
	checkStatus("zone 2", 8'h00, st);
endtask

/* tests/ym2610Tb.sv */
`timescale 1ns/100ps

module ym2610Tb;
	import ymRegPkg::*;
	import ymSoundPkg::*;

	localparam int clkPeriod = 20;
	localparam int busWriteCycles = 8;	// Address phase plus data phase
	localparam int busReadCycles = 5;
	localparam int tonePeriod = 5 * ssgPrescale;
	localparam int toneChecks = 4 * tonePeriod;
	localparam int envStepCycles = 1 * ssgPrescale * 16;
	localparam int envCycles = 17 * envStepCycles;
	localparam int timerAPeriod = (1024 - 1020) * taPrescale;
	localparam int timerBWait = (256 - 254) * tbPrescale + 64;
	localparam int watchdogCycles = 4 + 40 * busWriteCycles + 10 * busReadCycles
		+ 3 * tonePeriod + toneChecks + 2 * envCycles + timerAPeriod + 16
		+ timerBWait + 500;

	logic phiS;
	logic rst;
	logic [dataWidth-1:0] sddIn;
	logic [1:0] sda;
	logic nCs;
	logic nWr;
	logic nRd;
	logic [dataWidth-1:0] sddOut;
	logic nIrq;
	logic [anaWidth-1:0] ana;

	integer seed;
	int errors;

	ym2610 dut0(
		.phiS(phiS),
		.rst(rst),
		.sddIn(sddIn),
		.sda(sda),
		.nCs(nCs),
		.nWr(nWr),
		.nRd(nRd),
		.sddOut(sddOut),
		.nIrq(nIrq),
		.ana(ana)
	);

	initial
	begin
		phiS = 1'b0;
		forever #(clkPeriod / 2) phiS = ~phiS;
	end

	`include "ymTbTasks.svh"

	// Upper bound on the whole run
	initial
	begin
		#(watchdogCycles * clkPeriod);
		stopOnError("Watchdog timeout: the tests did not finish in time");
	end

	initial
	begin
		errors = 0;
		seed = 32'h8802af5f;
		rst = 1'b1;
		sddIn = '0;
		sda = 2'b00;
		nCs = 1'b1;
		nWr = 1'b1;
		nRd = 1'b1;
		repeat (4) @(posedge phiS);
		#2;
		rst = 1'b0;
		nextCycle();

		testResetAndVolumes();
		testTone();
		testEnvelopeSetup();
		testEnvelope("envelope attack", 4'hD, 6'd15, 1'b1);
		testEnvelope("envelope decay", 4'h9, 6'd0, 1'b0);
		testTimerA();
		testTimerB();
		testZoneTwo();

		if (errors == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
		begin
			$display("Simulation finished: FAIL");
			$fatal(1, "Errors found");
		end
	end

endmodule
